//--- filelist.f
cache_pkg.sv
line_counter.sv
cache_store.sv
cache_ctrl_fsm.sv
direct_mapped_cache.sv
separate_caches.sv
separate_caches_chk.sv
tb_separate_caches.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f filelist.f \
  --top-module tb_separate_caches -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^No errors$" "$log"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

//--- tb_separate_caches.sv
`default_nettype none

// word memory answering one cache with a random busy delay per request.
module mem_model (
  input  wire logic             clk,
  input  wire cache_pkg::addr_t addr,
  input  wire logic             ren,
  input  wire logic             wen,
  input  wire cache_pkg::word_t wdata,
  output cache_pkg::word_t      rdata,
  output logic                  busy
);

  cache_pkg::word_t words [256];
  cache_pkg::addr_t req_addr;
  cache_pkg::word_t req_data;
  cache_pkg::addr_t last_waddr;
  cache_pkg::word_t last_wdata;
  int               seed = 32'h439a02ed;
  int               delay = 0;
  logic             active = 1'b0;
  logic             is_write = 1'b0;
  int               reads = 0;
  int               writes = 0;
  int               ops = 0;                        // request order for sequencing checks.
  int               wr_seq = 0;
  int               rd_seq = 0;

  initial begin
    busy  = 1'b0;
    rdata = '0;
  end

  always @(negedge clk) begin
    if (active && !busy) begin                      // completed on the last rising edge.
      if (is_write) words[req_addr[9:2]] = req_data;
      active = 1'b0;
    end
    if (!active && (ren || wen)) begin
      active   = 1'b1;
      is_write = wen;
      req_addr = addr;
      req_data = wdata;
      delay    = $unsigned($random(seed)) % 4;
      ops++;
      if (wen) begin
        writes++;
        wr_seq     = ops;
        last_waddr = addr;
        last_wdata = wdata;
      end else begin
        reads++;
        rd_seq = ops;
      end
    end else if (active && delay > 0) begin
      delay--;
    end
    busy  = active && (delay != 0);
    rdata = words[req_addr[9:2]];
  end

endmodule

module tb_separate_caches;

  localparam int WAIT_LIMIT = 200;
  localparam cache_pkg::word_t IBASE = 32'h1c00_0000;
  localparam cache_pkg::word_t DBASE = 32'hd000_0000;

  logic                clk;
  logic                rst_n;
  cache_pkg::addr_t    icache_proc_addr, icache_mem_addr, dcache_proc_addr, dcache_mem_addr;
  cache_pkg::word_t    icache_proc_wdata, icache_proc_rdata, icache_mem_wdata, icache_mem_rdata;
  cache_pkg::word_t    dcache_proc_wdata, dcache_proc_rdata, dcache_mem_wdata, dcache_mem_rdata;
  logic [3:0]          icache_proc_byte_en, dcache_proc_byte_en;
  logic                icache_proc_ren, icache_proc_wen, icache_proc_busy;
  logic                icache_mem_ren, icache_mem_wen, icache_mem_busy;
  logic                icache_flush, icache_clear, icache_flush_done, icache_clear_done;
  logic                dcache_proc_ren, dcache_proc_wen, dcache_proc_busy;
  logic                dcache_mem_ren, dcache_mem_wen, dcache_mem_busy;
  logic                dcache_flush, dcache_clear, dcache_flush_done, dcache_clear_done;
  cache_pkg::word_t    ishadow [256];               // expected word per address.
  cache_pkg::word_t    dshadow [256];
  bit                  dmarked [256];               // written since the last flush.
  int                  seed = 32'h439a02ed;
  int                  checks = 0;
  int                  errors = 0;

  separate_caches #(.ICACHE_SETS(16), .DCACHE_SETS(8)) uut (.CLK(clk), .*);

  mem_model imem (.clk, .addr(icache_mem_addr), .ren(icache_mem_ren), .wen(icache_mem_wen),
                  .wdata(icache_mem_wdata), .rdata(icache_mem_rdata), .busy(icache_mem_busy));
  mem_model dmem (.clk, .addr(dcache_mem_addr), .ren(dcache_mem_ren), .wen(dcache_mem_wen),
                  .wdata(dcache_mem_wdata), .rdata(dcache_mem_rdata), .busy(dcache_mem_busy));

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ####################################################################
  // helpers
  // ####################################################################

  function automatic cache_pkg::word_t fill_word(cache_pkg::word_t base, cache_pkg::addr_t a);
    return base ^ (a * 32'h9e37_79b1) ^ {a[7:0], a[31:8]};
  endfunction

  function automatic cache_pkg::word_t merge_bytes(cache_pkg::word_t old_w,
                                                   cache_pkg::word_t new_w, logic [3:0] be);
    cache_pkg::word_t w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) w[8*b +: 8] = new_w[8*b +: 8];
    end
    return w;
  endfunction

  task automatic abort_run(input string what);
    $display("Timeout: %s", what);
    $display("checks %0d, check errors %0d", checks, errors + 1);
    $display("Errors found");
    $finish;
  endtask

  task automatic check_word(input string name, input cache_pkg::word_t expected,
                            input cache_pkg::word_t actual);
    checks++;
    assert (actual === expected) else begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // one processor request held until a cycle with busy low.
  task automatic access(input bit dside, input bit wr, input cache_pkg::addr_t a,
                        input cache_pkg::word_t wd, input logic [3:0] be,
                        output cache_pkg::word_t rd);
    int waited;
    waited = 0;
    @(negedge clk);
    if (dside) begin
      dcache_proc_addr    = a;
      dcache_proc_wdata   = wd;
      dcache_proc_byte_en = be;
      dcache_proc_ren     = !wr;
      dcache_proc_wen     = wr;
    end else begin
      icache_proc_addr    = a;
      icache_proc_wdata   = wd;
      icache_proc_byte_en = be;
      icache_proc_ren     = !wr;
      icache_proc_wen     = wr;
    end
    #1;
    while (dside ? dcache_proc_busy : icache_proc_busy) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("processor request stayed busy");
      @(negedge clk);
      #1;
    end
    rd = dside ? dcache_proc_rdata : icache_proc_rdata;   // valid in the completing cycle.
    @(negedge clk);
    {icache_proc_ren, icache_proc_wen, dcache_proc_ren, dcache_proc_wen} = '0;
  endtask

  task automatic write_data(input cache_pkg::addr_t a, input cache_pkg::word_t wd,
                            input logic [3:0] be);
    cache_pkg::word_t rd;
    access(1'b1, 1'b1, a, wd, be, rd);
    dshadow[a[9:2]] = merge_bytes(dshadow[a[9:2]], wd, be);
    dmarked[a[9:2]] = 1'b1;
  endtask

  task automatic read_check(input bit dside, input cache_pkg::addr_t a, input string name);
    cache_pkg::word_t rd;
    access(dside, 1'b0, a, '0, '0, rd);
    check_word(name, dside ? dshadow[a[9:2]] : ishadow[a[9:2]], rd);
  endtask

  function automatic logic walk_done(input bit dside, input bit do_clear);
    if (dside) return do_clear ? dcache_clear_done : dcache_flush_done;
    return do_clear ? icache_clear_done : icache_flush_done;
  endfunction

  task automatic set_level(input bit dside, input bit do_clear, input logic level);
    if (dside && do_clear) dcache_clear = level;
    else if (dside) dcache_flush = level;
    else if (do_clear) icache_clear = level;
    else icache_flush = level;
  endtask

  task automatic flush_or_clear(input bit dside, input bit do_clear);
    int waited;
    waited = 0;
    @(negedge clk);
    set_level(dside, do_clear, 1'b1);
    #1;
    while (!walk_done(dside, do_clear)) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("flush or clear never signalled done");
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    set_level(dside, do_clear, 1'b0);
    #1;
    check_word("done drops with its level", '0, 32'(walk_done(dside, do_clear)));
  endtask

  task automatic check_flushed();
    for (int i = 0; i < 256; i++) begin
      if (dmarked[i]) begin
        check_word("flushed word in memory", dshadow[i], dmem.words[i]);
        dmarked[i] = 1'b0;
      end
    end
  endtask

  // ####################################################################
  // stimulus
  // ####################################################################

  initial begin
    cache_pkg::addr_t a;
    cache_pkg::word_t lost_rd;
    int               r0;
    int               w0;
    int               other;
    bit               dside;
    int               asserts;

    rst_n = 1'b0;
    {icache_proc_ren, icache_proc_wen, icache_flush, icache_clear} = '0;
    {dcache_proc_ren, dcache_proc_wen, dcache_flush, dcache_clear} = '0;
    {icache_proc_addr, icache_proc_wdata, icache_proc_byte_en} = '0;
    {dcache_proc_addr, dcache_proc_wdata, dcache_proc_byte_en} = '0;
    for (int i = 0; i < 256; i++) begin
      imem.words[i] = fill_word(IBASE, 32'(i * 4));
      dmem.words[i] = fill_word(DBASE, 32'(i * 4));
      ishadow[i]    = fill_word(IBASE, 32'(i * 4));
      dshadow[i]    = fill_word(DBASE, 32'(i * 4));
      dmarked[i]    = 1'b0;
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_word("outputs quiet after reset", '0,
               32'({icache_proc_busy, icache_mem_ren, icache_mem_wen, icache_flush_done,
                    icache_clear_done, dcache_proc_busy, dcache_mem_ren, dcache_mem_wen,
                    dcache_flush_done, dcache_clear_done}));

    // read misses fill from memory and the repeat hits
    r0 = imem.reads;
    read_check(1'b0, 32'h40, "icache read miss");
    read_check(1'b0, 32'h40, "icache read hit");
    check_word("icache memory reads", r0 + 1, imem.reads);
    r0 = dmem.reads;
    read_check(1'b1, 32'h10c, "dcache read miss");
    read_check(1'b1, 32'h10c, "dcache read hit");
    check_word("dcache memory reads", r0 + 1, dmem.reads);

    w0 = dmem.writes;
    write_data(32'h10c, 32'ha1b2_c3d4, 4'b0110);
    read_check(1'b1, 32'h10c, "dcache merged write hit");
    check_word("no memory write on hit", w0, dmem.writes);

    // 0x12c maps onto the dirty line of 0x10c
    a  = 32'h10c;
    w0 = dmem.writes;
    r0 = dmem.reads;
    read_check(1'b1, 32'h12c, "dcache conflict miss");
    check_word("one write-back", w0 + 1, dmem.writes);
    check_word("one fill", r0 + 1, dmem.reads);
    check_word("write-back address", a, dmem.last_waddr);
    check_word("write-back data", dshadow[a[9:2]], dmem.last_wdata);
    check_word("write-back before fill", dmem.wr_seq + 1, dmem.rd_seq);

    for (int k = 0; k < 4; k++) begin
      write_data(32'h200 + 32'(k * 4), $random(seed), k[0] ? 4'b0011 : 4'b1111);
    end
    flush_or_clear(1'b1, 1'b0);
    check_flushed();
    r0 = dmem.reads;
    read_check(1'b1, 32'h204, "read after flush");
    check_word("flushed line stays cached", r0, dmem.reads);
    flush_or_clear(1'b0, 1'b0);
    check_word("icache never writes memory", '0, imem.writes);

    // the shadow keeps the old word since the clear drops the write
    a = 32'h304;
    access(1'b1, 1'b1, a, 32'h5a5a_0f0f, 4'b1111, lost_rd);
    flush_or_clear(1'b1, 1'b1);
    r0 = dmem.reads;
    read_check(1'b1, a, "read after clear");
    check_word("clear forces a refill", r0 + 1, dmem.reads);
    flush_or_clear(1'b0, 1'b1);

    for (int n = 0; n < 48; n++) begin
      dside = n[0];
      a     = 32'($random(seed)) & 32'h0000_00fc;
      other = dside ? imem.reads + imem.writes : dmem.reads + dmem.writes;
      if (dside && ($random(seed) & 1)) write_data(a, $random(seed), 4'($random(seed)));
      else read_check(dside, a, "random read");
      check_word("other memory port idle", other,
                 dside ? imem.reads + imem.writes : dmem.reads + dmem.writes);
    end
    flush_or_clear(1'b1, 1'b0);
    check_flushed();

    asserts = uut.icache.chk.fail_count + uut.dcache.chk.fail_count;
    $display("checks %0d, check errors %0d, assertion errors %0d", checks, errors, asserts);
    if (errors == 0 && asserts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- separate_caches_chk.sv
`default_nettype none

module separate_caches_chk (
  input wire logic             CLK,
  input wire logic             rst_n,
  input wire logic             proc_ren,
  input wire logic             proc_wen,
  input wire cache_pkg::addr_t mem_addr,
  input wire logic             mem_ren,
  input wire logic             mem_wen,
  input wire cache_pkg::word_t mem_wdata,
  input wire logic             mem_busy,
  input wire logic             flush,
  input wire logic             clear,
  input wire logic             flush_done
);

  int fail_count = 0;                               // failed assertions so far.

  // ####################################################################
  // memory bus protocol
  // ####################################################################

  a_mem_exclusive: assert property (@(posedge CLK) disable iff (!rst_n)
      !(mem_ren && mem_wen))
    else begin
      $error("memory read and write requested in the same cycle");
      fail_count++;
    end

  // a stalled request keeps its kind, address and write data.
  a_mem_hold: assert property (@(posedge CLK) disable iff (!rst_n)
      $past((mem_ren || mem_wen) && mem_busy) |->
        (mem_ren == $past(mem_ren) && mem_wen == $past(mem_wen) &&
         mem_addr == $past(mem_addr) && (!mem_wen || mem_wdata == $past(mem_wdata))))
    else begin
      $error("memory request changed while the memory was busy");
      fail_count++;
    end

  a_mem_cause: assert property (@(posedge CLK) disable iff (!rst_n)
      (mem_ren || mem_wen) |-> (proc_ren || proc_wen || flush || clear))
    else begin
      $error("memory request with no processor request, flush or clear");
      fail_count++;
    end

  // once raised, done stays high exactly as long as flush is held.
  a_flush_done: assert property (@(posedge CLK) disable iff (!rst_n)
      (flush_done || $past(flush_done)) |-> (flush_done == flush))
    else begin
      $error("flush_done high without flush or dropped while flush was held");
      fail_count++;
    end

endmodule

bind direct_mapped_cache separate_caches_chk chk (
  .CLK, .rst_n, .proc_ren, .proc_wen,
  .mem_addr, .mem_ren, .mem_wen, .mem_wdata, .mem_busy,
  .flush, .clear, .flush_done
);

`default_nettype wire

//--- separate_caches.sv
`default_nettype none

// instruction and data caches side by side, no sharing between them.
module separate_caches #(
  parameter int ICACHE_SETS = 16,
  parameter int DCACHE_SETS = 8
) (
  input  wire logic                               CLK,
  input  wire logic                               rst_n,
  // ##################################################################
  // instruction side
  // ##################################################################
  input  wire cache_pkg::addr_t                   icache_proc_addr,
  input  wire logic                               icache_proc_ren,
  input  wire logic                               icache_proc_wen,
  input  wire cache_pkg::word_t                   icache_proc_wdata,
  input  wire logic [cache_pkg::WORD_BYTES-1:0]   icache_proc_byte_en,
  output cache_pkg::word_t                        icache_proc_rdata,
  output logic                                    icache_proc_busy,
  output cache_pkg::addr_t                        icache_mem_addr,
  output logic                                    icache_mem_ren,
  output logic                                    icache_mem_wen,
  output cache_pkg::word_t                        icache_mem_wdata,
  input  wire cache_pkg::word_t                   icache_mem_rdata,
  input  wire logic                               icache_mem_busy,
  input  wire logic                               icache_flush,
  input  wire logic                               icache_clear,
  output logic                                    icache_flush_done,
  output logic                                    icache_clear_done,
  // ##################################################################
  // data side
  // ##################################################################
  input  wire cache_pkg::addr_t                   dcache_proc_addr,
  input  wire logic                               dcache_proc_ren,
  input  wire logic                               dcache_proc_wen,
  input  wire cache_pkg::word_t                   dcache_proc_wdata,
  input  wire logic [cache_pkg::WORD_BYTES-1:0]   dcache_proc_byte_en,
  output cache_pkg::word_t                        dcache_proc_rdata,
  output logic                                    dcache_proc_busy,
  output cache_pkg::addr_t                        dcache_mem_addr,
  output logic                                    dcache_mem_ren,
  output logic                                    dcache_mem_wen,
  output cache_pkg::word_t                        dcache_mem_wdata,
  input  wire cache_pkg::word_t                   dcache_mem_rdata,
  input  wire logic                               dcache_mem_busy,
  input  wire logic                               dcache_flush,
  input  wire logic                               dcache_clear,
  output logic                                    dcache_flush_done,
  output logic                                    dcache_clear_done
);

  direct_mapped_cache #(.SETS(ICACHE_SETS)) icache (
    .CLK, .rst_n,
    .proc_addr    (icache_proc_addr),
    .proc_ren     (icache_proc_ren),
    .proc_wen     (icache_proc_wen),
    .proc_wdata   (icache_proc_wdata),
    .proc_byte_en (icache_proc_byte_en),
    .proc_rdata   (icache_proc_rdata),
    .proc_busy    (icache_proc_busy),
    .mem_addr     (icache_mem_addr),
    .mem_ren      (icache_mem_ren),
    .mem_wen      (icache_mem_wen),
    .mem_wdata    (icache_mem_wdata),
    .mem_rdata    (icache_mem_rdata),
    .mem_busy     (icache_mem_busy),
    .flush        (icache_flush),
    .clear        (icache_clear),
    .flush_done   (icache_flush_done),
    .clear_done   (icache_clear_done)
  );

  direct_mapped_cache #(.SETS(DCACHE_SETS)) dcache (
    .CLK, .rst_n,
    .proc_addr    (dcache_proc_addr),
    .proc_ren     (dcache_proc_ren),
    .proc_wen     (dcache_proc_wen),
    .proc_wdata   (dcache_proc_wdata),
    .proc_byte_en (dcache_proc_byte_en),
    .proc_rdata   (dcache_proc_rdata),
    .proc_busy    (dcache_proc_busy),
    .mem_addr     (dcache_mem_addr),
    .mem_ren      (dcache_mem_ren),
    .mem_wen      (dcache_mem_wen),
    .mem_wdata    (dcache_mem_wdata),
    .mem_rdata    (dcache_mem_rdata),
    .mem_busy     (dcache_mem_busy),
    .flush        (dcache_flush),
    .clear        (dcache_clear),
    .flush_done   (dcache_flush_done),
    .clear_done   (dcache_clear_done)
  );

endmodule

`default_nettype wire

//--- direct_mapped_cache.sv
`default_nettype none

module direct_mapped_cache #(
  parameter int SETS = 16
) (
  input  wire logic                                   CLK,
  input  wire logic                                   rst_n,
  input  wire cache_pkg::addr_t                       proc_addr,
  input  wire logic                                   proc_ren,
  input  wire logic                                   proc_wen,
  input  wire cache_pkg::word_t                       proc_wdata,
  input  wire logic [cache_pkg::WORD_BYTES-1:0]       proc_byte_en,
  output cache_pkg::word_t                            proc_rdata,
  output logic                                        proc_busy,
  output cache_pkg::addr_t                            mem_addr,
  output logic                                        mem_ren,
  output logic                                        mem_wen,
  output cache_pkg::word_t                            mem_wdata,
  input  wire cache_pkg::word_t                       mem_rdata,
  input  wire logic                                   mem_busy,
  input  wire logic                                   flush,
  input  wire logic                                   clear,
  output logic                                        flush_done,
  output logic                                        clear_done
);

  localparam int IDX_W = $clog2(SETS);
  localparam int OFF_W = cache_pkg::OFFSET_W;

  logic              hit, dirty, valid, last;
  logic              cnt_start, cnt_step, use_walk;
  logic              fill, write, clean, invalidate;
  logic              mem_sel_victim;
  logic [IDX_W-1:0]  walk_index;
  cache_pkg::addr_t  victim_addr;
  cache_pkg::addr_t  line_addr;
  cache_pkg::word_t  store_rdata;

  assign line_addr  = {proc_addr[cache_pkg::ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
  assign mem_addr   = mem_sel_victim ? victim_addr : line_addr;
  assign mem_wdata  = store_rdata;                  // only ever the selected line.
  assign proc_rdata = store_rdata;

  cache_ctrl_fsm ctrl (
    .CLK, .rst_n,
    .proc_ren, .proc_wen, .proc_busy,
    .flush, .clear, .flush_done, .clear_done,
    .hit, .dirty, .valid, .last,
    .cnt_start, .cnt_step, .use_walk,
    .fill, .write, .clean, .invalidate,
    .mem_ren, .mem_wen, .mem_busy, .mem_sel_victim
  );

  line_counter #(.SETS(SETS)) walker (
    .CLK, .rst_n,
    .start (cnt_start),
    .step  (cnt_step),
    .index (walk_index),
    .last
  );

  cache_store #(.SETS(SETS)) store (
    .CLK, .rst_n,
    .lookup_addr (proc_addr),
    .walk_index, .use_walk,
    .hit, .dirty, .valid, .victim_addr,
    .rdata       (store_rdata),
    .fill,
    .fill_data   (mem_rdata),
    .write,
    .wdata       (proc_wdata),
    .byte_en     (proc_byte_en),
    .clean, .invalidate
  );

endmodule

`default_nettype wire

//--- cache_ctrl_fsm.sv
`default_nettype none

module cache_ctrl_fsm (
  input  wire logic CLK,
  input  wire logic rst_n,
  input  wire logic proc_ren,
  input  wire logic proc_wen,
  output logic      proc_busy,
  input  wire logic flush,
  input  wire logic clear,
  output logic      flush_done,
  output logic      clear_done,
  input  wire logic hit,
  input  wire logic dirty,
  input  wire logic valid,
  input  wire logic last,
  output logic      cnt_start,
  output logic      cnt_step,
  output logic      use_walk,
  output logic      fill,
  output logic      write,
  output logic      clean,
  output logic      invalidate,
  output logic      mem_ren,
  output logic      mem_wen,
  input  wire logic mem_busy,
  output logic      mem_sel_victim
);

  cache_pkg::cache_state_e state;
  cache_pkg::cache_state_e next_state;
  logic                    is_flush;                // which walk led to done.
  logic                    proc_req;
  logic                    serve_hit;

  assign proc_req  = proc_ren || proc_wen;
  // flush and clear win over a new request, only checked in idle.
  assign serve_hit = (state == cache_pkg::idle) && hit && !flush && !clear;

  assign proc_busy  = proc_req && !serve_hit;
  assign write      = proc_wen && serve_hit;
  assign flush_done = (state == cache_pkg::done) && is_flush && flush;
  assign clear_done = (state == cache_pkg::done) && !is_flush && clear;

  // ####################################################################
  // state register
  // ####################################################################

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state    <= cache_pkg::idle;
      is_flush <= 1'b0;
    end else begin
      state <= next_state;
      if (state == cache_pkg::idle && (flush || clear)) is_flush <= flush;
    end
  end

  // ####################################################################
  // next state and one-cycle store commands
  // ####################################################################

  always_comb begin
    next_state     = state;
    cnt_start      = 1'b0;
    cnt_step       = 1'b0;
    use_walk       = 1'b0;
    fill           = 1'b0;
    clean          = 1'b0;
    invalidate     = 1'b0;
    mem_ren        = 1'b0;
    mem_wen        = 1'b0;
    mem_sel_victim = 1'b0;

    unique case (state)
      cache_pkg::idle: begin
        if (flush || clear) begin
          cnt_start  = 1'b1;
          next_state = flush ? cache_pkg::walk_flush : cache_pkg::walk_clear;
        end else if (proc_req && !hit) begin
          // a dirty victim goes out before the new word comes in.
          next_state = (valid && dirty) ? cache_pkg::write_back : cache_pkg::fill;
        end
      end
      cache_pkg::write_back: begin
        mem_wen        = 1'b1;
        mem_sel_victim = 1'b1;
        if (!mem_busy) next_state = cache_pkg::fill;
      end
      cache_pkg::fill: begin
        mem_ren = 1'b1;
        if (!mem_busy) begin
          fill       = 1'b1;                        // the request hits next cycle.
          next_state = cache_pkg::idle;
        end
      end
      cache_pkg::walk_flush: begin
        use_walk = 1'b1;
        if (valid && dirty) begin
          mem_wen        = 1'b1;
          mem_sel_victim = 1'b1;
          if (!mem_busy) begin
            clean    = 1'b1;
            cnt_step = 1'b1;
            if (last) next_state = cache_pkg::done;
          end
        end else begin
          cnt_step = 1'b1;                          // clean lines take one cycle.
          if (last) next_state = cache_pkg::done;
        end
      end
      cache_pkg::walk_clear: begin
        use_walk   = 1'b1;
        invalidate = 1'b1;
        cnt_step   = 1'b1;
        if (last) next_state = cache_pkg::done;
      end
      cache_pkg::done: begin
        if (is_flush ? !flush : !clear) next_state = cache_pkg::idle;
      end
      default: next_state = cache_pkg::idle;
    endcase
  end

endmodule

`default_nettype wire

//--- cache_store.sv
`default_nettype none

module cache_store #(
  parameter int SETS = 16,
  localparam int IDX_W = $clog2(SETS)
) (
  input  wire logic                                   CLK,
  input  wire logic                                   rst_n,
  input  wire cache_pkg::addr_t                       lookup_addr,
  input  wire logic             [IDX_W-1:0]           walk_index,
  input  wire logic                                   use_walk,
  output logic                                        hit,
  output logic                                        dirty,
  output logic                                        valid,
  output cache_pkg::addr_t                            victim_addr,
  output cache_pkg::word_t                            rdata,
  input  wire logic                                   fill,
  input  wire cache_pkg::word_t                       fill_data,
  input  wire logic                                   write,
  input  wire cache_pkg::word_t                       wdata,
  input  wire logic [cache_pkg::WORD_BYTES-1:0]       byte_en,
  input  wire logic                                   clean,
  input  wire logic                                   invalidate
);

  localparam int OFF_W = cache_pkg::OFFSET_W;
  localparam int TAG_W = cache_pkg::ADDR_W - IDX_W - OFF_W;

  logic [TAG_W-1:0]  tag_mem [SETS];
  cache_pkg::word_t  data_mem [SETS];
  logic [SETS-1:0]   valid_bits;
  logic [SETS-1:0]   dirty_bits;
  logic [IDX_W-1:0]  addr_index;
  logic [IDX_W-1:0]  sel_index;
  logic [TAG_W-1:0]  addr_tag;
  cache_pkg::word_t  merged;

  // ####################################################################
  // lookup
  // ####################################################################

  assign addr_index = lookup_addr[OFF_W +: IDX_W];
  assign addr_tag   = lookup_addr[cache_pkg::ADDR_W-1 -: TAG_W];
  assign sel_index  = use_walk ? walk_index : addr_index;   // walk overrides the request.

  assign valid       = valid_bits[sel_index];
  assign dirty       = dirty_bits[sel_index];
  assign hit         = valid && (tag_mem[sel_index] == addr_tag);
  assign victim_addr = {tag_mem[sel_index], sel_index, {OFF_W{1'b0}}};
  assign rdata       = data_mem[sel_index];

  always_comb begin
    merged = data_mem[sel_index];
    for (int b = 0; b < cache_pkg::WORD_BYTES; b++) begin
      if (byte_en[b]) begin
        merged[8*b +: 8] = wdata[8*b +: 8];         // only enabled bytes change.
      end
    end
  end

  // ####################################################################
  // state bits and arrays
  // ####################################################################

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      if (fill) begin
        valid_bits[sel_index] <= 1'b1;              // fresh line matches memory.
        dirty_bits[sel_index] <= 1'b0;
      end
      if (write) dirty_bits[sel_index] <= 1'b1;
      if (clean) dirty_bits[sel_index] <= 1'b0;     // written back during flush.
      if (invalidate) begin
        valid_bits[sel_index] <= 1'b0;
        dirty_bits[sel_index] <= 1'b0;              // dirty data is dropped.
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (fill) begin
      tag_mem[sel_index]  <= addr_tag;
      data_mem[sel_index] <= fill_data;
    end else if (write) begin
      data_mem[sel_index] <= merged;
    end
  end

endmodule

`default_nettype wire

//--- line_counter.sv
`default_nettype none

// steps through the line indices for the flush and clear walks.
module line_counter #(
  parameter int SETS = 16,
  localparam int IDX_W = $clog2(SETS)
) (
  input  wire logic             CLK,
  input  wire logic             rst_n,
  input  wire logic             start,
  input  wire logic             step,
  output logic      [IDX_W-1:0] index,
  output logic                  last
);

  localparam logic [IDX_W-1:0] LAST_INDEX = IDX_W'(SETS - 1);

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      index <= '0;
    end else if (start) begin
      index <= '0;                                  // walk always begins at line zero.
    end else if (step) begin
      index <= index + 1'b1;                        // wraps to zero after the last line.
    end
  end

  assign last = (index == LAST_INDEX);

endmodule

`default_nettype wire

//--- cache_pkg.sv
`default_nettype none

package cache_pkg;

  // ####################################################################
  // bus widths
  // ####################################################################

  localparam int ADDR_W = 32;                       // byte address width.
  localparam int WORD_W = 32;                       // data word width.
  localparam int WORD_BYTES = 4;                    // bytes in one line.
  localparam int OFFSET_W = $clog2(WORD_BYTES);     // ignored low address bits.

  typedef logic [ADDR_W-1:0] addr_t;                // processor and memory address.
  typedef logic [WORD_W-1:0] word_t;                // processor and memory data.

  // ####################################################################
  // controller states
  // ####################################################################

  // tag width is left to each module, it depends on SETS.
  typedef enum logic [2:0] {
    idle,                                           // serve hits, detect misses.
    write_back,                                     // victim word out to memory.
    fill,                                           // requested word in from memory.
    walk_flush,                                     // write back every dirty line.
    walk_clear,                                     // invalidate every line.
    done                                            // hold done until the level drops.
  } cache_state_e;

endpackage

`default_nettype wire
